//--- rrs_settings.svh
`ifndef RRS_SETTINGS_SVH
`define RRS_SETTINGS_SVH

// ========================================
// register-read stage sizes
// ========================================

// functional-unit requesters, one register number each per cycle
`define RRS_NREQ 12

// read ports on the register file
`define RRS_NPORT 6

// requesters tied 1:1 to ports 0 .. RRS_NFIXED-1 and served every cycle
`define RRS_NFIXED 3

// architectural registers, register zero reads as zero
`define RRS_NREG 64
`define RRS_REG_W 6
`define RRS_DATA_W 32

// wide enough to name any read port
`define RRS_PORT_W 3

`endif

//--- rrs_pkg.sv
`default_nettype none

`include "rrs_settings.svh"

// shared types of the register-read stage
package rrs_pkg;

	// architectural register number, a value of zero means no request
	typedef logic [`RRS_REG_W-1:0] areg_t;

	// value held in one architectural register
	typedef logic [`RRS_DATA_W-1:0] reg_data_t;

	// index of a register-file read port
	typedef logic [`RRS_PORT_W-1:0] port_idx_t;

endpackage

`default_nettype wire

//--- read_port_select.sv
`default_nettype none
`timescale 1ns/100ps

`include "rrs_settings.svh"

module read_port_select (
	input wire clk,
	input wire rst,
	input wire rrs_pkg::areg_t [`RRS_NREQ-1:0] areg_i,
	output rrs_pkg::areg_t [`RRS_NPORT-1:0] port_reg_o,
	output logic [`RRS_NREQ-1:0] grant_o,
	output rrs_pkg::port_idx_t [`RRS_NREQ-1:0] grant_port_o
);

	// requesters that compete for the dynamic ports
	localparam int NDYN = `RRS_NREQ - `RRS_NFIXED;
	// ports left over once the fixed requesters have theirs
	localparam int NDYN_PORT = `RRS_NPORT - `RRS_NFIXED;

	// rotation pointer into the dynamic requesters, counts 0 .. NDYN-1
	logic [$clog2(NDYN)-1:0] rot_ptr;

	rrs_pkg::areg_t [`RRS_NPORT-1:0] nxt_port_reg;
	logic [`RRS_NREQ-1:0] nxt_grant;
	rrs_pkg::port_idx_t [`RRS_NREQ-1:0] nxt_grant_port;

	// the pointer moves on by one every cycle whether or not anyone asked,
	// so every dynamic requester gets the head of the scan once per NDYN cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			rot_ptr <= '0;
		end else if (rot_ptr == NDYN - 1) begin
			rot_ptr <= '0;
		end else begin
			rot_ptr <= rot_ptr + 1'b1;
		end
	end

	// ========================================
	// port assignment
	// ========================================

	always_comb begin : scan
		rrs_pkg::port_idx_t k;
		int idx;
		k = rrs_pkg::port_idx_t'(`RRS_NFIXED);
		idx = 0;
		nxt_port_reg = '0;
		nxt_grant = '0;
		nxt_grant_port = '0;
		// fixed requesters own their port even for register zero,
		// which simply reads back a zero
		for (int h = 0; h < `RRS_NFIXED; h++) begin
			nxt_port_reg[h] = areg_i[h];
			nxt_grant[h] = 1'b1;
			nxt_grant_port[h] = rrs_pkg::port_idx_t'(h);
		end
		// walk the dynamic requesters from the pointer and wrap at the end
		for (int j = 0; j < NDYN; j++) begin
			idx = j + int'(rot_ptr);
			if (idx >= NDYN) begin
				idx = idx - NDYN;
			end
			idx = idx + `RRS_NFIXED;
			// once the ports run out the rest of the scan is dropped
			if (areg_i[idx] != '0 && k < `RRS_NPORT) begin
				nxt_grant[idx] = 1'b1;
				nxt_grant_port[idx] = k;
				nxt_port_reg[k] = areg_i[idx];
				k = k + 1'b1;
			end
		end
	end

	// grants are control state and clear on reset, the register numbers
	// and port indices only matter where a grant is set
	always_ff @(posedge clk) begin
		if (rst) begin
			grant_o <= '0;
		end else begin
			grant_o <= nxt_grant;
		end
		port_reg_o <= nxt_port_reg;
		grant_port_o <= nxt_grant_port;
	end

	// ========================================
	// checks
	// ========================================

	// the dynamic side can never hand out more ports than it has
	a_dyn_grant_count: assert property (@(posedge clk) disable iff (rst)
		$countones(grant_o[`RRS_NREQ-1:`RRS_NFIXED]) <= NDYN_PORT);

	// a dynamic request for register zero is no request at all
	for (genvar g = `RRS_NFIXED; g < `RRS_NREQ; g++) begin : g_zero_chk
		a_no_zero_grant: assert property (@(posedge clk) disable iff (rst)
			areg_i[g] == '0 |=> !grant_o[g]);
	end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none
`timescale 1ns/100ps

`include "rrs_settings.svh"

module reg_file (
	input wire clk,
	input wire rst,
	input wire rrs_pkg::areg_t [`RRS_NPORT-1:0] port_reg_i,
	input wire wr_en_i,
	input wire rrs_pkg::areg_t wr_reg_i,
	input wire rrs_pkg::reg_data_t wr_data_i,
	output rrs_pkg::reg_data_t [`RRS_NPORT-1:0] port_data_o
);

	rrs_pkg::reg_data_t regs [`RRS_NREG];

	// ========================================
	// write port
	// ========================================

	// reset clears the whole array, and since register zero is never
	// written it stays zero from then on
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `RRS_NREG; r++) begin
				regs[r] <= '0;
			end
		end else if (wr_en_i && wr_reg_i != '0) begin
			regs[wr_reg_i] <= wr_data_i;
		end
	end

	// ========================================
	// read ports
	// ========================================

	// every port samples the array at the same edge as the write,
	// so a read racing a write to the same register returns the old value
	always_ff @(posedge clk) begin
		for (int p = 0; p < `RRS_NPORT; p++) begin
			port_data_o[p] <= regs[port_reg_i[p]];
		end
	end

	// register zero must stay clear whatever the write port does
	a_reg0_zero: assert property (@(posedge clk) disable iff (rst)
		regs[0] == '0);

endmodule

`default_nettype wire

//--- read_data_route.sv
`default_nettype none
`timescale 1ns/100ps

`include "rrs_settings.svh"

module read_data_route (
	input wire clk,
	input wire rst,
	input wire [`RRS_NREQ-1:0] grant_i,
	input wire rrs_pkg::port_idx_t [`RRS_NREQ-1:0] grant_port_i,
	input wire rrs_pkg::reg_data_t [`RRS_NPORT-1:0] port_data_i,
	output logic [`RRS_NREQ-1:0] ack_o,
	output rrs_pkg::reg_data_t [`RRS_NREQ-1:0] rd_data_o
);

	// grant map held back one edge to sit alongside the register-file data
	logic [`RRS_NREQ-1:0] grant_q;
	rrs_pkg::port_idx_t [`RRS_NREQ-1:0] grant_port_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			grant_q <= '0;
		end else begin
			grant_q <= grant_i;
		end
		grant_port_q <= grant_port_i;
	end

	// ========================================
	// return path
	// ========================================

	// each acknowledged requester pulls the data of the port it was given,
	// the others see zero
	always_comb begin
		for (int r = 0; r < `RRS_NREQ; r++) begin
			ack_o[r] = grant_q[r];
			if (grant_q[r]) begin
				rd_data_o[r] = port_data_i[grant_port_q[r]];
			end else begin
				rd_data_o[r] = '0;
			end
		end
	end

	// a port carries one register per cycle, so two requesters acknowledged
	// together must have been given different ports by the selector
	for (genvar a = 0; a < `RRS_NREQ; a++) begin : g_pair_a
		for (genvar b = a + 1; b < `RRS_NREQ; b++) begin : g_pair_b
			a_port_unique: assert property (@(posedge clk) disable iff (rst)
				!(ack_o[a] && ack_o[b] && grant_port_q[a] == grant_port_q[b]));
		end
	end

endmodule

`default_nettype wire

//--- reg_read_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "rrs_settings.svh"

module reg_read_top (
	input wire clk,
	input wire rst,
	input wire rrs_pkg::areg_t [`RRS_NREQ-1:0] areg_i,
	input wire wr_en_i,
	input wire rrs_pkg::areg_t wr_reg_i,
	input wire rrs_pkg::reg_data_t wr_data_i,
	output logic [`RRS_NREQ-1:0] ack_o,
	output rrs_pkg::reg_data_t [`RRS_NREQ-1:0] rd_data_o
);

	// selector outputs, one edge after the request
	rrs_pkg::areg_t [`RRS_NPORT-1:0] port_reg;
	logic [`RRS_NREQ-1:0] grant;
	rrs_pkg::port_idx_t [`RRS_NREQ-1:0] grant_port;

	// register-file outputs, two edges after the request
	rrs_pkg::reg_data_t [`RRS_NPORT-1:0] port_data;

	read_port_select u_sel (
		.clk(clk),
		.rst(rst),
		.areg_i(areg_i),
		.port_reg_o(port_reg),
		.grant_o(grant),
		.grant_port_o(grant_port)
	);

	reg_file u_rf (
		.clk(clk),
		.rst(rst),
		.port_reg_i(port_reg),
		.wr_en_i(wr_en_i),
		.wr_reg_i(wr_reg_i),
		.wr_data_i(wr_data_i),
		.port_data_o(port_data)
	);

	read_data_route u_route (
		.clk(clk),
		.rst(rst),
		.grant_i(grant),
		.grant_port_i(grant_port),
		.port_data_i(port_data),
		.ack_o(ack_o),
		.rd_data_o(rd_data_o)
	);

endmodule

`default_nettype wire

//--- tb_reg_read.sv
`default_nettype none
`timescale 1ns/100ps

`include "rrs_settings.svh"

module tb_reg_read;

	localparam int NDYN = `RRS_NREQ - `RRS_NFIXED;
	localparam int NDYN_PORT = `RRS_NPORT - `RRS_NFIXED;
	// a held request is served within one pointer lap plus the pipeline
	localparam int HOLD_LIMIT = 4 * `RRS_NREQ;
	localparam int DRAIN_LIMIT = 10;

	logic clk;
	logic rst;
	rrs_pkg::areg_t [`RRS_NREQ-1:0] areg;
	logic wr_en;
	rrs_pkg::areg_t wr_reg;
	rrs_pkg::reg_data_t wr_data;
	logic [`RRS_NREQ-1:0] ack_o;
	rrs_pkg::reg_data_t [`RRS_NREQ-1:0] rd_data_o;

	// ========================================
	// reference model state
	// ========================================

	// set by the stimulus while every requester is kept busy
	logic busy_phase;
	logic [31:0] rng_state;
	rrs_pkg::reg_data_t model_mem [`RRS_NREG];
	// request history, d2 lines up with the acknowledges seen at an edge
	rrs_pkg::areg_t [`RRS_NREQ-1:0] req_d1;
	rrs_pkg::areg_t [`RRS_NREQ-1:0] req_d2;
	rrs_pkg::reg_data_t [`RRS_NREQ-1:0] exp_data;
	logic rst_d1;
	logic rst_d2;
	logic busy_d1;
	logic busy_d2;
	logic chk_on;
	logic [7:0] idle_cnt [`RRS_NREQ];

	reg_read_top uut (
		.clk(clk),
		.rst(rst),
		.areg_i(areg),
		.wr_en_i(wr_en),
		.wr_reg_i(wr_reg),
		.wr_data_i(wr_data),
		.ack_o(ack_o),
		.rd_data_o(rd_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// LCG step, constants of the usual 32-bit generator
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// a busy requester always names a nonzero register,
	// otherwise about one request in four is idle
	function automatic rrs_pkg::areg_t pick_register(input logic busy);
		logic [31:0] r;
		rrs_pkg::areg_t a;
		r = next_rand();
		a = r[`RRS_REG_W+15:16];
		if (busy && a == '0) begin
			a = rrs_pkg::areg_t'(1);
		end else if (!busy && r[31:30] == 2'b00) begin
			a = '0;
		end
		return a;
	endfunction

	// the dynamic side grants at most one request per dynamic port
	function automatic int expected_grants(input rrs_pkg::areg_t [`RRS_NREQ-1:0] req);
		int n;
		n = 0;
		for (int i = `RRS_NFIXED; i < `RRS_NREQ; i++) begin
			if (req[i] != '0) begin
				n++;
			end
		end
		return (n < NDYN_PORT) ? n : NDYN_PORT;
	endfunction

	task automatic print_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("RESULT: FAIL");
	endtask

	// the model follows the DUT edge for edge, reads see the old contents
	always @(posedge clk) begin
		rst_d1 <= rst;
		rst_d2 <= rst_d1;
		req_d1 <= areg;
		req_d2 <= req_d1;
		busy_d1 <= busy_phase;
		busy_d2 <= busy_d1;
		for (int i = 0; i < `RRS_NREQ; i++) begin
			exp_data[i] <= model_mem[req_d1[i]];
		end
		if (rst) begin
			for (int r = 0; r < `RRS_NREG; r++) begin
				model_mem[r] <= '0;
			end
		end else if (wr_en && wr_reg != '0) begin
			model_mem[wr_reg] <= wr_data;
		end
		// count cycles without an acknowledge while everyone is busy
		for (int i = 0; i < `RRS_NREQ; i++) begin
			if (rst || !busy_d2 || ack_o[i]) begin
				idle_cnt[i] <= '0;
			end else begin
				idle_cnt[i] <= idle_cnt[i] + 8'd1;
			end
		end
	end

	// acknowledges only mean something once the request two edges back
	// was taken outside reset
	assign chk_on = !rst_d1 && !rst_d2;

	// ========================================
	// checks
	// ========================================

	// until the first request taken outside reset comes back the outputs stay quiet,
	// which covers the whole reset and the cycle right after it
	a_reset_quiet: assert property (@(posedge clk)
		chk_on || (ack_o == '0 && rd_data_o == '0))
	else begin
		print_error("acknowledge or data active during reset");
		$fatal(1, "reset check");
	end

	a_grant_count: assert property (@(posedge clk) disable iff (rst)
		!chk_on || $countones(ack_o[`RRS_NREQ-1:`RRS_NFIXED]) == expected_grants(req_d2))
	else begin
		print_error("number of dynamic acknowledges is wrong");
		$fatal(1, "grant count check");
	end

	for (genvar g = 0; g < `RRS_NREQ; g++) begin : g_req_chk
		a_data: assert property (@(posedge clk) disable iff (rst)
			!(chk_on && ack_o[g]) || rd_data_o[g] == exp_data[g])
		else begin
			print_error($sformatf("requester %0d returned wrong data", g));
			$fatal(1, "data check");
		end
		if (g < `RRS_NFIXED) begin : g_fixed
			a_fixed_ack: assert property (@(posedge clk) disable iff (rst)
				!chk_on || ack_o[g])
			else begin
				print_error($sformatf("fixed requester %0d not acknowledged", g));
				$fatal(1, "fixed check");
			end
		end else begin : g_dyn
			a_zero_idle: assert property (@(posedge clk) disable iff (rst)
				!(chk_on && req_d2[g] == '0) || !ack_o[g])
			else begin
				print_error($sformatf("requester %0d acknowledged for register zero", g));
				$fatal(1, "zero request check");
			end
			a_no_starve: assert property (@(posedge clk) disable iff (rst)
				!chk_on || idle_cnt[g] < NDYN)
			else begin
				print_error($sformatf("requester %0d starved while busy", g));
				$fatal(1, "starvation check");
			end
		end
	end

	// ========================================
	// stimulus
	// ========================================

	// one cycle of random requests, wr_odds out of eight cycles also write
	task automatic drive_cycle(input logic busy, input int wr_odds);
		logic [31:0] r;
		@(negedge clk);
		for (int i = 0; i < `RRS_NREQ; i++) begin
			areg[i] = pick_register(busy);
		end
		r = next_rand();
		wr_en = int'(r[2:0]) < wr_odds;
		wr_reg = r[`RRS_REG_W+7:8];
		wr_data = next_rand();
		busy_phase = busy;
	endtask

	// keep one dynamic request up under full load until it comes back
	task automatic hold_until_ack(input int idx, input rrs_pkg::areg_t a);
		int waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < HOLD_LIMIT) begin
			drive_cycle(1'b1, 0);
			areg[idx] = a;
			// the first two acknowledges still belong to older requests
			if (waited >= 2 && ack_o[idx]) begin
				seen = 1'b1;
			end
			waited++;
		end
		if (!seen) begin
			$display("timeout: requester %0d not acknowledged in %0d cycles", idx, HOLD_LIMIT);
			$display("RESULT: FAIL");
			$fatal(1, "hold timeout");
		end
	endtask

	// after the requests stop the dynamic acknowledges must die out
	task automatic wait_dyn_idle();
		int waited;
		waited = 0;
		while (ack_o[`RRS_NREQ-1:`RRS_NFIXED] != '0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (ack_o[`RRS_NREQ-1:`RRS_NFIXED] != '0) begin
			$display("timeout: dynamic acknowledges still active after requests stopped");
			$display("RESULT: FAIL");
			$fatal(1, "drain timeout");
		end
	endtask

	initial begin : stimulus
		rng_state = 32'hf02c6208;
		rst = 1'b1;
		areg = '0;
		wr_en = 1'b0;
		wr_reg = '0;
		wr_data = '0;
		busy_phase = 1'b0;
		rst_d1 = 1'b0;
		rst_d2 = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// fill every register, register zero included, which must stay zero
		for (int r = 0; r < `RRS_NREG; r++) begin
			@(negedge clk);
			for (int i = 0; i < `RRS_NREQ; i++) begin
				areg[i] = pick_register(1'b0);
			end
			wr_en = 1'b1;
			wr_reg = rrs_pkg::areg_t'(r);
			wr_data = next_rand();
		end
		for (int c = 0; c < 400; c++) begin
			drive_cycle(1'b0, 1);
		end
		for (int i = `RRS_NFIXED; i < `RRS_NREQ; i++) begin
			hold_until_ack(i, pick_register(1'b1));
		end
		// every requester busy, so the rotation alone decides the grants
		for (int c = 0; c < 120; c++) begin
			drive_cycle(1'b1, 1);
		end
		@(negedge clk);
		areg = '0;
		wr_en = 1'b0;
		busy_phase = 1'b0;
		wait_dyn_idle();
		repeat (4) @(negedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
rrs_pkg.sv
read_port_select.sv
reg_file.sv
read_data_route.sv
reg_read_top.sv
tb_reg_read.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the register-read stage testbench with Verilator and run it into sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing -Wno-fatal --top-module tb_reg_read \
	-f sim.f -o sim_tb \
	|| { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "no result found in sim.log"; exit 1; }
exit 0
